//--- src/cam_config_pkg.sv
`default_nettype none

package cam_config_pkg;

    // Init table geometry
    localparam int ROM_AW = 8;                          // Table index width
    localparam int ROM_DW = 16;                         // Sub-address in high byte, value in low

    // Marker words decoded by the sequencer
    localparam logic [ROM_DW-1:0] TABLE_END   = 16'hFFFF; // Stop walking the table
    localparam logic [ROM_DW-1:0] TABLE_DELAY = 16'hFFF0; // Insert one settle delay

    // Settle delay per marker, short for simulation
    localparam int DELAY_CYCLES = 2000;                  // Clocks per delay marker
    localparam int DELAY_W      = $clog2(DELAY_CYCLES + 1); // Delay counter width

    // SCCB bus timing and framing
    localparam int SCCB_HALF = 8;                        // Clocks per half sioc period
    localparam int HALF_W    = $clog2(SCCB_HALF);        // Half-period divider width
    localparam int SCCB_BITS = 27;                       // ID, sub-address, value, 9 bits each
    localparam int BIT_W     = $clog2(SCCB_BITS);        // Bit counter width

    // Camera write address on the bus
    localparam logic [7:0] SCCB_ID = 8'h42;              // OV7670 write ID

endpackage

`default_nettype wire

//--- src/cam_reg_rom.sv
`timescale 1ns/10ps
`default_nettype none

module cam_reg_rom import cam_config_pkg::*; (
    input  logic              clk,
    input  logic [ROM_AW-1:0] rom_addr,
    output logic [ROM_DW-1:0] rom_data
);

    // One cycle from address to word, no reset on the data
    always_ff @(posedge clk) begin
        case (rom_addr)
            8'd0:  rom_data <= 16'h12_80;    // COM7 soft reset of all registers
            8'd1:  rom_data <= TABLE_DELAY;  // Let the sensor come out of reset
            8'd2:  rom_data <= TABLE_DELAY;
            8'd3:  rom_data <= TABLE_DELAY;  // Third settle period
            8'd4:  rom_data <= 16'h12_14;    // COM7 QVGA frame, RGB out
            8'd5:  rom_data <= 16'h11_80;    // CLKRC pixel clock straight from input
            8'd6:  rom_data <= 16'h0C_04;    // COM3 scaling enable bit only
            8'd7:  rom_data <= 16'h3E_19;    // COM14 pclk divider, manual scale
            8'd8:  rom_data <= 16'h04_00;    // COM1 no CCIR656 framing
            8'd9:  rom_data <= 16'h40_D0;    // COM15 RGB565 over 00..FF
            8'd10: rom_data <= 16'h3A_04;    // TSLB output sequence
            8'd11: rom_data <= 16'h14_18;    // COM9 gain ceiling 4x
            8'd12: rom_data <= 16'h4F_B3;    // Color matrix coefficient 1
            8'd13: rom_data <= 16'h50_B3;    // Coefficient 2
            8'd14: rom_data <= 16'h51_00;    // Coefficient 3
            8'd15: rom_data <= 16'h52_3D;    // Coefficient 4
            8'd16: rom_data <= 16'h53_A7;    // Coefficient 5
            8'd17: rom_data <= 16'h54_E4;    // Coefficient 6
            8'd18: rom_data <= 16'h58_9E;    // Matrix sign bits
            8'd19: rom_data <= 16'h3D_C0;    // COM13 gamma and UV saturation
            8'd20: rom_data <= 16'h17_15;    // HSTART upper bits
            8'd21: rom_data <= 16'h18_03;    // HSTOP upper bits
            8'd22: rom_data <= 16'h32_00;    // HREF edge offsets
            8'd23: rom_data <= 16'h19_03;    // VSTART upper bits
            8'd24: rom_data <= 16'h1A_7B;    // VSTOP upper bits
            8'd25: rom_data <= 16'h03_00;    // VREF low bits
            8'd26: rom_data <= 16'h0F_41;    // COM6 reset timing on format change
            8'd27: rom_data <= 16'h1E_00;    // MVFP no mirror, no flip
            8'd28: rom_data <= 16'h33_0B;    // CHLF array current
            8'd29: rom_data <= 16'h3C_78;    // COM12 HREF gated by VSYNC
            8'd30: rom_data <= 16'h69_00;    // GFIX per-channel gain fix
            8'd31: rom_data <= 16'h74_00;    // REG74 digital gain from VREF
            8'd32: rom_data <= 16'hB0_84;    // Reserved, needed for color balance
            8'd33: rom_data <= 16'hB1_0C;    // ABLC1 black level auto
            8'd34: rom_data <= 16'hB2_0E;    // Reserved
            8'd35: rom_data <= 16'hB3_80;    // THL_ST black level target
            8'd36: rom_data <= 16'h70_3A;    // SCALING_XSC test pattern off
            8'd37: rom_data <= 16'h71_35;    // SCALING_YSC
            8'd38: rom_data <= 16'h72_11;    // DCW down-sample by 2
            8'd39: rom_data <= 16'h73_F1;    // PCLK divider for scaling
            8'd40: rom_data <= 16'hA2_02;    // Pixel clock delay
            8'd41: rom_data <= 16'h7A_20;    // Gamma slope
            8'd42: rom_data <= 16'h7B_10;    // Gamma curve point 1
            8'd43: rom_data <= 16'h7C_1E;
            8'd44: rom_data <= 16'h7D_35;
            8'd45: rom_data <= 16'h7E_5A;
            8'd46: rom_data <= 16'h7F_69;
            8'd47: rom_data <= 16'h80_76;
            8'd48: rom_data <= 16'h81_80;
            8'd49: rom_data <= 16'h82_88;
            8'd50: rom_data <= 16'h83_8F;
            8'd51: rom_data <= 16'h84_96;
            8'd52: rom_data <= 16'h85_A3;
            8'd53: rom_data <= 16'h86_AF;
            8'd54: rom_data <= 16'h87_C4;
            8'd55: rom_data <= 16'h88_D7;
            8'd56: rom_data <= 16'h89_E8;    // Gamma curve point 15
            8'd57: rom_data <= 16'h13_E0;    // COM8 AGC and AEC off while set up
            8'd58: rom_data <= 16'h00_00;    // GAIN cleared
            8'd59: rom_data <= 16'h10_00;    // AECH cleared
            8'd60: rom_data <= 16'h0D_40;    // COM4 reserved bit
            8'd61: rom_data <= 16'h14_18;    // COM9 again, 4x gain ceiling
            8'd62: rom_data <= 16'hA5_05;    // 50 Hz banding step limit
            8'd63: rom_data <= 16'hAB_07;    // 60 Hz banding step limit
            8'd64: rom_data <= 16'h24_95;    // AEW upper exposure bound
            8'd65: rom_data <= 16'h25_33;    // AEB lower exposure bound
            8'd66: rom_data <= 16'h26_E3;    // VPT fast-mode region
            8'd67: rom_data <= 16'h9F_78;    // Histogram AEC 1
            8'd68: rom_data <= 16'hA0_68;    // Histogram AEC 2
            8'd69: rom_data <= 16'hA1_03;    // Reserved
            8'd70: rom_data <= 16'hA6_D8;    // Histogram AEC 3
            8'd71: rom_data <= 16'hA7_D8;    // Histogram AEC 4
            8'd72: rom_data <= 16'hA8_F0;    // Histogram AEC 5
            8'd73: rom_data <= 16'hA9_90;    // Histogram AEC 6
            8'd74: rom_data <= 16'hAA_94;    // Histogram AEC 7
            8'd75: rom_data <= 16'h13_E7;    // COM8 AGC, AWB, AEC back on
            8'd76: rom_data <= TABLE_END;    // Last table word
            default: rom_data <= TABLE_END;  // Anything past the table ends it
        endcase
    end

endmodule

`default_nettype wire

//--- src/cam_config_seq.sv
`timescale 1ns/10ps
`default_nettype none

module cam_config_seq import cam_config_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,     // Begin a table walk
    output logic              busy,      // High while walking
    output logic              done,      // One cycle at end of table
    output logic [ROM_AW-1:0] rom_addr,
    input  logic [ROM_DW-1:0] rom_data,
    output logic              wr_start,  // Write request to SCCB master
    output logic [7:0]        wr_addr,
    output logic [7:0]        wr_data,
    input  logic              wr_busy,
    input  logic              wr_done
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FETCH,      // Address on the ROM
        ST_DECODE,     // ROM word valid
        ST_WR_WAIT,    // SCCB write in flight
        ST_DELAY,      // Settle delay
        ST_FINISH      // Done strobe
    } state_t;

    state_t             state;
    logic [ROM_AW-1:0]  index;      // Current table entry
    logic [DELAY_W-1:0] dly_cnt;    // Clocks spent in the delay
    logic               is_end;
    logic               is_delay;
    logic               dly_last;

    // Marker decode lives only here
    assign is_end   = (rom_data == TABLE_END);
    assign is_delay = (rom_data == TABLE_DELAY);
    assign dly_last = (dly_cnt == DELAY_W'(DELAY_CYCLES - 1));

    assign rom_addr = index;
    assign wr_addr  = rom_data[ROM_DW-1 -: 8];  // Upper byte is sub-address
    assign wr_data  = rom_data[7:0];            // Lower byte is value

    // Strobe only for ordinary words
    assign wr_start = (state == ST_DECODE) && !is_end && !is_delay;

    // Busy drops together with done
    assign busy = (state != ST_IDLE) && (state != ST_FINISH);
    assign done = (state == ST_FINISH);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            index   <= '0;
            dly_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        index <= '0;          // Always restart at the first entry
                        state <= ST_FETCH;
                    end
                end
                ST_FETCH: begin
                    state <= ST_DECODE;       // ROM registers the word this cycle
                end
                ST_DECODE: begin
                    if (is_end) begin
                        state <= ST_FINISH;
                    end else if (is_delay) begin
                        dly_cnt <= '0;
                        state   <= ST_DELAY;
                    end else if (!wr_busy) begin
                        state <= ST_WR_WAIT;  // wr_start fires this cycle
                    end
                end
                ST_WR_WAIT: begin
                    if (wr_done) begin
                        index <= index + 1'b1;
                        state <= ST_FETCH;
                    end
                end
                ST_DELAY: begin
                    if (dly_last) begin
                        index <= index + 1'b1;
                        state <= ST_FETCH;
                    end else begin
                        dly_cnt <= dly_cnt + 1'b1;
                    end
                end
                ST_FINISH: begin
                    if (start) begin          // Not busy here, so a new run may begin
                        index <= '0;
                        state <= ST_FETCH;
                    end else begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/sccb_write_master.sv
`timescale 1ns/10ps
`default_nettype none

module sccb_write_master import cam_config_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       wr_start,   // Begin one three-phase write
    input  logic [7:0] wr_addr,    // Register sub-address
    input  logic [7:0] wr_data,    // Register value
    output logic       wr_busy,
    output logic       wr_done,    // One cycle after the stop condition
    output logic       sioc,       // SCCB clock, idle high
    output logic       siod_oe     // 1 pulls siod low, 0 releases it
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_START,   // Data low under high clock, then clock low
        S_DATA,    // 27 bits, two halves each
        S_STOP     // Clock high, then data released
    } state_t;

    state_t               state;
    logic [HALF_W-1:0]    div_cnt;   // Clocks within a half period
    logic [1:0]           half;      // Half index within the phase
    logic [BIT_W-1:0]     bit_cnt;   // Bit being sent
    logic [SCCB_BITS-1:0] shreg;     // MSB is the next bit on the line
    logic                 tick;      // Last clock of a half period
    logic                 last_bit;
    logic                 shift_en;

    assign tick     = (div_cnt == HALF_W'(SCCB_HALF - 1));
    assign last_bit = (bit_cnt == BIT_W'(SCCB_BITS - 1));
    assign wr_busy  = (state != S_IDLE);

    // Shift when the next bit goes onto the line
    assign shift_en = tick && (half == 2'd1) &&
                      ((state == S_START) || ((state == S_DATA) && !last_bit));

    // Payload, ninth bit of each byte is a released 1
    always_ff @(posedge clk) begin
        if ((state == S_IDLE) && wr_start) begin
            shreg <= {SCCB_ID, 1'b1, wr_addr, 1'b1, wr_data, 1'b1};
        end else if (shift_en) begin
            shreg <= {shreg[SCCB_BITS-2:0], 1'b1};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= S_IDLE;
            div_cnt <= '0;
            half    <= '0;
            bit_cnt <= '0;
            sioc    <= 1'b1;
            siod_oe <= 1'b0;
            wr_done <= 1'b0;
        end else begin
            wr_done <= 1'b0;
            if (state == S_IDLE) begin
                div_cnt <= '0;
                if (wr_start) begin
                    state   <= S_START;
                    half    <= '0;
                    siod_oe <= 1'b1;               // Start, data falls while clock high
                end
            end else begin
                div_cnt <= tick ? '0 : div_cnt + 1'b1;
                if (tick) begin
                    case (state)
                        S_START: begin
                            if (half == 2'd0) begin
                                sioc <= 1'b0;
                                half <= 2'd1;
                            end else begin
                                state   <= S_DATA;
                                half    <= 2'd0;
                                bit_cnt <= '0;
                                siod_oe <= ~shreg[SCCB_BITS-1]; // First ID bit
                            end
                        end
                        S_DATA: begin
                            if (half == 2'd0) begin
                                sioc <= 1'b1;              // Bit valid on rising clock
                                half <= 2'd1;
                            end else begin
                                sioc <= 1'b0;
                                half <= 2'd0;
                                if (last_bit) begin
                                    state   <= S_STOP;
                                    siod_oe <= 1'b1;       // Hold low ahead of stop
                                end else begin
                                    bit_cnt <= bit_cnt + 1'b1;
                                    siod_oe <= ~shreg[SCCB_BITS-1];
                                end
                            end
                        end
                        S_STOP: begin
                            if (half == 2'd0) begin
                                sioc <= 1'b1;
                                half <= 2'd1;
                            end else if (half == 2'd1) begin
                                siod_oe <= 1'b0;           // Stop, data rises under high clock
                                half    <= 2'd2;
                            end else begin
                                state   <= S_IDLE;
                                wr_done <= 1'b1;
                            end
                        end
                        default: state <= S_IDLE;
                    endcase
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- src/cam_config_top.sv
`timescale 1ns/10ps
`default_nettype none

module cam_config_top import cam_config_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic start,     // Kick off camera init
    output logic busy,
    output logic done,
    output logic sioc,      // SCCB clock pin
    output logic siod_oe    // Open-drain enable for the SCCB data pin
);

    logic [ROM_AW-1:0] rom_addr;
    logic [ROM_DW-1:0] rom_data;
    logic              wr_start;   // Sequencer to master
    logic [7:0]        wr_addr;
    logic [7:0]        wr_data;
    logic              wr_busy;    // Master back to sequencer
    logic              wr_done;

    cam_reg_rom i_rom (
        .clk      (clk),
        .rom_addr (rom_addr),
        .rom_data (rom_data)
    );

    cam_config_seq i_seq (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .busy     (busy),
        .done     (done),
        .rom_addr (rom_addr),
        .rom_data (rom_data),
        .wr_start (wr_start),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .wr_busy  (wr_busy),
        .wr_done  (wr_done)
    );

    sccb_write_master i_sccb (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_start (wr_start),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .wr_busy  (wr_busy),
        .wr_done  (wr_done),
        .sioc     (sioc),
        .siod_oe  (siod_oe)
    );

endmodule

`default_nettype wire

//--- sim/cam_config_properties.sv
`timescale 1ns/10ps
`default_nettype none

module cam_config_properties (
    input logic       clk,
    input logic       rst_n,
    input logic       sioc,
    input logic       siod_oe,
    input logic [1:0] state,     // SCCB master phase
    input logic       wr_start,
    input logic       wr_busy,
    input logic       done
);

    localparam logic [1:0] PH_START = 2'd1;   // Master start phase encoding
    localparam logic [1:0] PH_STOP  = 2'd3;   // Master stop phase encoding

    // Data may only move under a high clock when framing a write
    line_moves_in_low_clock: assert property (@(posedge clk) disable iff (!rst_n)
        $changed(siod_oe) |-> (!sioc || state == PH_START || state == PH_STOP))
        else $error("siod moved under high sioc outside a start or stop");

    // Idle bus keeps the clock high
    clock_high_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !wr_busy |-> sioc)
        else $error("sioc low while the master is idle");

    // No new write on top of one in flight
    no_start_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
        wr_start |-> !wr_busy)
        else $error("wr_start issued while the master was busy");

    done_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !done)
        else $error("done held for more than one cycle");

endmodule

// Bus side, no done here
bind sccb_write_master cam_config_properties i_bus_props (
    .clk      (clk),
    .rst_n    (rst_n),
    .sioc     (sioc),
    .siod_oe  (siod_oe),
    .state    (state),
    .wr_start (wr_start),
    .wr_busy  (wr_busy),
    .done     (1'b0)
);

// Sequencer side, bus pins tied to idle
bind cam_config_seq cam_config_properties i_seq_props (
    .clk      (clk),
    .rst_n    (rst_n),
    .sioc     (1'b1),
    .siod_oe  (1'b0),
    .state    (2'd0),
    .wr_start (wr_start),
    .wr_busy  (wr_busy),
    .done     (done)
);

`default_nettype wire

//--- sim/cam_config_tb.sv
`timescale 1ns/10ps
`default_nettype none

module cam_config_tb import cam_config_pkg::*; ();

    localparam int TABLE_LEN    = 77;                               // Words in the table file
    localparam int RUNS         = 5;                                // Three full, one cut, one after
    localparam int WRITE_CYCLES = (2 + 2 * 27 + 3) * SCCB_HALF + 4; // Start, bits, stop, fetch

    logic clk;
    logic rst_n;
    logic start;
    logic busy;
    logic done;
    logic sioc;
    logic siod_oe;

    logic [15:0] table_img [0:TABLE_LEN-1];
    logic [15:0] exp_q [$];           // Expected writes in order
    int          n_exp;
    bit          model_ready;
    logic [31:0] rng;
    int          run_id;              // Bumped by the stimulus per run
    int          main_errs;
    int          mon_errs;

    // Bus decoder state
    int          cyc;
    bit          prev_sioc;
    bit          prev_line;
    bit          in_frame;
    int          nbits;
    logic [26:0] frame_bits;          // ID, ninth, addr, ninth, value, ninth
    int          wr_idx;
    int          mon_run;
    int          first_stop;

    cam_config_top i_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (start),
        .busy    (busy),
        .done    (done),
        .sioc    (sioc),
        .siod_oe (siod_oe)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_pin(input string name, input int exp, input int got);
        assert (got == exp) else begin
            $display("FAILED at %0t: %s expected %0h, got %0h", $time, name, exp, got);
            main_errs++;
        end
    endtask

    task automatic check_bus(input string name, input int exp, input int got);
        assert (got == exp) else begin
            $display("FAILED at %0t: %s expected %0h, got %0h", $time, name, exp, got);
            mon_errs++;
        end
    endtask

    // Bus decoder, samples the pins on each rising clk
    always @(posedge clk) begin
        logic line;
        line = ~siod_oe;                               // Pull-up reads high when released
        cyc++;
        if (!rst_n) begin
            in_frame = 1'b0;
            nbits    = 0;
        end else begin
            if (run_id != mon_run) begin
                mon_run = run_id;
                wr_idx  = 0;
            end
            if (prev_sioc && sioc && prev_line && !line) begin      // Start condition
                assert (!in_frame) else begin
                    $display("Start condition at %0t inside an open write", $time);
                    mon_errs++;
                end
                assert (wr_idx < n_exp) else begin
                    $display("Extra write at %0t after the table ended", $time);
                    mon_errs++;
                end
                if (wr_idx == 1) begin
                    assert (cyc - first_stop >= 3 * DELAY_CYCLES) else begin
                        $display("Settle gap of %0d cycles is too short", cyc - first_stop);
                        mon_errs++;
                    end
                end
                in_frame = 1'b1;
                nbits    = 0;
            end else if (prev_sioc && sioc && !prev_line && line) begin  // Stop condition
                assert (in_frame) else begin
                    $display("Stop condition at %0t without a start", $time);
                    mon_errs++;
                end
                check_bus("sioc pulses per write", 28, nbits);      // 27 bits plus stop setup
                if (in_frame && wr_idx < n_exp) begin
                    check_bus("siod id byte", int'(SCCB_ID), int'(frame_bits[26:19]));
                    check_bus("siod sub-address byte", int'(exp_q[wr_idx][15:8]),
                              int'(frame_bits[17:10]));
                    check_bus("siod value byte", int'(exp_q[wr_idx][7:0]),
                              int'(frame_bits[8:1]));
                end
                if (wr_idx == 0) begin
                    first_stop = cyc;
                end
                wr_idx++;
                in_frame = 1'b0;
            end else if (!prev_sioc && sioc && in_frame) begin      // Bit on rising sioc
                nbits++;
                if (nbits <= 27) begin
                    frame_bits = {frame_bits[25:0], line};
                    if (nbits % 9 == 0) begin
                        assert (line) else begin
                            $display("Ninth bit of byte %0d pulled low at %0t", nbits / 9, $time);
                            mon_errs++;
                        end
                    end
                end
            end
            if (done) begin
                check_bus("writes before done", n_exp, wr_idx);
                assert (!in_frame) else begin
                    $display("done at %0t with a write still open", $time);
                    mon_errs++;
                end
            end
        end
        prev_sioc = sioc;
        prev_line = line;
    end

    task automatic launch_run(input int gap);
        run_id++;
        repeat (gap) @(posedge clk);
        #1 start = 1'b1;
        @(posedge clk);
        #1 start = 1'b0;
        check_pin("busy", 1, int'(busy));              // Up one cycle after start
    endtask

    task automatic run_full(input int gap);
        int late_done;
        bit late_busy;
        late_done = 0;
        late_busy = 1'b0;
        launch_run(gap);
        while (!done) begin
            rng   = xorshift32(rng);
            start = busy && (rng[5:0] == 6'd0);        // Stray strobes while busy
            @(posedge clk);
            #1;
        end
        start = 1'b0;
        check_pin("busy", 0, int'(busy));              // Falls with done
        repeat (WRITE_CYCLES) begin
            @(posedge clk);
            #1;
            if (done) late_done++;
            if (busy) late_busy = 1'b1;
        end
        check_pin("done strobes after end", 0, late_done);
        assert (!late_busy) else begin
            $display("busy rose again after done at %0t", $time);
            main_errs++;
        end
    endtask

    // Watchdog sized from the model
    initial begin
        int limit;
        wait (model_ready);
        limit = 4 * RUNS * (n_exp * WRITE_CYCLES + 3 * DELAY_CYCLES);
        repeat (limit) @(posedge clk);
        $display("Timeout after %0d cycles without reaching the end", limit);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        int cut_at;
        rst_n     = 1'b0;
        start     = 1'b0;
        rng       = 32'h89a5;
        run_id    = 0;
        main_errs = 0;
        mon_errs  = 0;
        $readmemh("sim/cam_init_expected.mem", table_img);
        for (int i = 0; i < TABLE_LEN; i++) begin
            if (table_img[i] == 16'hFFFF) break;       // End of table
            if (table_img[i] != 16'hFFF0) begin        // Delays produce no write
                exp_q.push_back(table_img[i]);
            end
        end
        n_exp       = exp_q.size();
        model_ready = 1'b1;
        check_pin("expected write count", 73, n_exp);

        repeat (5) @(posedge clk);
        #1 rst_n = 1'b1;

        for (int r = 0; r < 3; r++) begin
            rng = xorshift32(rng);
            run_full(5 + int'(rng % 200));
        end

        // Fourth run cut short by reset
        rng    = xorshift32(rng);
        cut_at = 3 * DELAY_CYCLES + int'(rng % (n_exp * WRITE_CYCLES / 2));
        launch_run(10);
        repeat (cut_at) @(posedge clk);
        #1 rst_n = 1'b0;
        #1;
        check_pin("sioc", 1, int'(sioc));
        check_pin("siod_oe", 0, int'(siod_oe));
        check_pin("busy", 0, int'(busy));
        repeat (5) @(posedge clk);
        #1 rst_n = 1'b1;

        rng = xorshift32(rng);
        run_full(5 + int'(rng % 200));                // Full table again from entry 0

        $display("Errors: stimulus %0d, bus %0d, total %0d",
                 main_errs, mon_errs, main_errs + mon_errs);
        if (main_errs + mon_errs == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- cam_config_top.f
src/cam_config_pkg.sv
src/cam_reg_rom.sv
src/cam_config_seq.sv
src/sccb_write_master.sv
src/cam_config_top.sv
sim/cam_config_properties.sv
sim/cam_config_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= cam_config_tb
FILELIST  ?= cam_config_top.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, look for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

//--- sim/cam_init_expected.mem
// Each line holds one table word in hex
// High byte is the sub-address and low byte the value
// FFF0 marks a settle delay and FFFF ends the table
1280
FFF0
FFF0
FFF0
1214
1180
0C04
3E19
0400
40D0
3A04
1418
4FB3
50B3
5100
523D
53A7
54E4
589E
3DC0
1715
1803
3200
1903
1A7B
0300
0F41
1E00
330B
3C78
6900
7400
B084
B10C
B20E
B380
703A
7135
7211
73F1
A202
7A20
7B10
7C1E
7D35
7E5A
7F69
8076
8180
8288
838F
8496
85A3
86AF
87C4
88D7
89E8
13E0
0000
1000
0D40
1418
A505
AB07
2495
2533
26E3
9F78
A068
A103
A6D8
A7D8
A8F0
A990
AA94
13E7
FFFF
